//--- gpio_ctrl_pkg.sv
`default_nettype none

package gpio_ctrl_pkg;

    // Pad and configuration word sizes
    localparam int IO_PADS      = 16;
    localparam int IO_CTRL_BITS = 13;
    localparam int PAD_IDX_W    = 4;
    localparam int BIT_IDX_W    = 4;   // Counts bits within one configuration word

    localparam int OEB_BIT      = 1;   // Output enable bar
    localparam int INP_DIS_BIT  = 3;   // Input disable, also drives the pad output enable

    // Address map, only bits 31:8 of the base take part in the compare
    localparam logic [31:0] BASE_ADR    = 32'h2300_0000;
    localparam logic [7:0]  DATA_OFS    = 8'h00;
    localparam logic [7:0]  XFER_OFS    = 8'h04;
    localparam logic [7:0]  IO_CTRL_OFS = 8'h20;   // Pad i at IO_CTRL_OFS + 4*i

    // Default pad configurations
    localparam logic [IO_CTRL_BITS-1:0] CTRL_RESET_BIDIR = 13'h1801;
    // Simple input pad, output driver disabled through the OEB bit
    localparam logic [IO_CTRL_BITS-1:0] CTRL_RESET_INPUT =
        13'h0401 | (13'd1 << OEB_BIT);

    typedef enum logic [1:0] {
        REGION_NONE    = 2'd0,
        REGION_DATA    = 2'd1,
        REGION_XFER    = 2'd2,
        REGION_IO_CTRL = 2'd3
    } reg_region_e;

    typedef enum logic [1:0] {
        LD_IDLE  = 2'd0,
        LD_START = 2'd1,
        LD_SHIFT = 2'd2,
        LD_LATCH = 2'd3
    } loader_state_e;

    // Raw Wishbone request from the management bus
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_req_t;

    // Decoded access handed to the register stage
    typedef struct packed {
        logic                 valid;   // Request hits this block
        reg_region_e          region;
        logic [PAD_IDX_W-1:0] pad;
        logic                 write;   // Qualified by byte lane 0
        logic [31:0]          wdata;
    } reg_access_t;

    // Lines into the external pad configuration chain
    typedef struct packed {
        logic clock;
        logic resetn;
        logic data;
    } serial_out_t;

    // One configuration word per pad, pad 0 in the lowest slot
    typedef logic [IO_PADS-1:0][IO_CTRL_BITS-1:0] pad_ctrl_t;

endpackage

`default_nettype wire

//--- wb_bus_decode.sv
`default_nettype none

module wb_bus_decode (
    input  gpio_ctrl_pkg::wb_req_t     req_i,
    output gpio_ctrl_pkg::reg_access_t access_o
);
    import gpio_ctrl_pkg::*;

    logic [7:0] ofs;
    logic [7:0] ctrl_rel;    // Offset relative to pad 0 register
    logic       base_hit;
    logic       ctrl_hit;

    assign ofs      = req_i.adr[7:0];
    assign ctrl_rel = ofs - IO_CTRL_OFS;
    assign base_hit = (req_i.adr[31:8] == BASE_ADR[31:8]);

    // Word aligned and within the pad register window
    assign ctrl_hit = (ofs >= IO_CTRL_OFS)
                   && (ctrl_rel[1:0] == 2'b00)
                   && (ctrl_rel[7:2] < IO_PADS);

    always_comb begin
        access_o.valid  = req_i.cyc && req_i.stb && base_hit;
        access_o.write  = req_i.we && req_i.sel[0];   // Upper lanes alone never write
        access_o.wdata  = req_i.dat;
        access_o.pad    = '0;
        access_o.region = REGION_NONE;

        if (ofs == DATA_OFS) begin
            access_o.region = REGION_DATA;
        end else if (ofs == XFER_OFS) begin
            access_o.region = REGION_XFER;
        end else if (ctrl_hit) begin
            access_o.region = REGION_IO_CTRL;
            access_o.pad    = ctrl_rel[PAD_IDX_W+1:2];
        end
    end

endmodule

`default_nettype wire

//--- gpio_ctrl_regs.sv
`default_nettype none

module gpio_ctrl_regs (
    input  wire                                clk,
    input  wire                                resetn,
    input  gpio_ctrl_pkg::reg_access_t         access_i,
    input  wire [gpio_ctrl_pkg::IO_PADS-1:0]   mgmt_gpio_in_i,
    input  wire                                busy_i,
    output logic [31:0]                        rdata_o,
    output logic                               ack_o,
    output logic                               xfer_start_o,
    output gpio_ctrl_pkg::pad_ctrl_t           pad_ctrl_o,
    output logic [gpio_ctrl_pkg::IO_PADS-1:0]  mgmt_gpio_out_o,
    output logic [gpio_ctrl_pkg::IO_PADS-1:0]  mgmt_gpio_oe_o
);
    import gpio_ctrl_pkg::*;

    logic               ack_q;
    logic               xfer_start_q;
    logic [31:0]        rdata_q;
    logic [IO_PADS-1:0] gpio_out_q;
    pad_ctrl_t          io_ctrl_q;

    logic               accept;
    logic               wr_data;
    logic               wr_xfer;
    logic               wr_ctrl;

    // A held strobe is taken again only after ack has dropped
    assign accept  = access_i.valid && !ack_q;

    assign wr_data = accept && access_i.write && (access_i.region == REGION_DATA);
    assign wr_xfer = accept && access_i.write && (access_i.region == REGION_XFER);
    assign wr_ctrl = accept && access_i.write && (access_i.region == REGION_IO_CTRL);

    // Bus handshake and transfer trigger
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ack_q        <= 1'b0;
            xfer_start_q <= 1'b0;
        end else begin
            ack_q        <= accept;
            xfer_start_q <= wr_xfer && access_i.wdata[0];   // Self clearing
        end
    end

    // GPIO output data word
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            gpio_out_q <= '0;
        end else if (wr_data) begin
            gpio_out_q <= access_i.wdata[IO_PADS-1:0];
        end
    end

    // Per pad configuration words
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < IO_PADS; i++) begin
                // Pads 0 and 1 come up bidirectional, the rest as inputs
                io_ctrl_q[i] <= (i < 2) ? CTRL_RESET_BIDIR : CTRL_RESET_INPUT;
            end
        end else if (wr_ctrl) begin
            io_ctrl_q[access_i.pad] <= access_i.wdata[IO_CTRL_BITS-1:0];
        end
    end

    // Read data is captured on acceptance and shown together with ack
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rdata_q <= '0;
        end else if (accept) begin
            case (access_i.region)
                REGION_DATA:    rdata_q <= {{(32-IO_PADS){1'b0}}, mgmt_gpio_in_i};
                REGION_XFER:    rdata_q <= {31'd0, busy_i};
                REGION_IO_CTRL: rdata_q <= {{(32-IO_CTRL_BITS){1'b0}},
                                            io_ctrl_q[access_i.pad]};
                default:        rdata_q <= 32'd0;   // Unmapped offset reads zero
            endcase
        end
    end

    // Output enable follows the input disable bit of each pad
    always_comb begin
        for (int i = 0; i < IO_PADS; i++) begin
            mgmt_gpio_oe_o[i] = io_ctrl_q[i][INP_DIS_BIT];
        end
    end

    assign mgmt_gpio_out_o = gpio_out_q;
    assign pad_ctrl_o      = io_ctrl_q;
    assign rdata_o         = rdata_q;
    assign ack_o           = ack_q;
    assign xfer_start_o    = xfer_start_q;

endmodule

`default_nettype wire

//--- pad_serial_loader.sv
`default_nettype none

module pad_serial_loader (
    input  wire                        clk,
    input  wire                        resetn,
    input  wire                        xfer_start_i,
    input  gpio_ctrl_pkg::pad_ctrl_t   pad_ctrl_i,
    output logic                       busy_o,
    output gpio_ctrl_pkg::serial_out_t serial_o
);
    import gpio_ctrl_pkg::*;

    loader_state_e         state_q;
    logic [PAD_IDX_W-1:0]  pad_q;       // Pad being shifted, counts down
    logic [BIT_IDX_W-1:0]  bit_q;       // Bit within word, also latch step
    logic                  clock_q;
    logic                  resetn_q;
    logic [IO_CTRL_BITS-1:0] staging_q;

    logic                  last_bit;
    logic                  last_pad;

    assign last_bit = (bit_q == BIT_IDX_W'(IO_CTRL_BITS - 1));
    assign last_pad = (pad_q == '0);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q  <= LD_IDLE;
            pad_q    <= PAD_IDX_W'(IO_PADS - 1);
            bit_q    <= '0;
            clock_q  <= 1'b0;
            resetn_q <= 1'b0;   // Chain held in reset until first idle cycle
        end else begin
            case (state_q)
                LD_IDLE: begin
                    resetn_q <= 1'b1;
                    clock_q  <= 1'b0;
                    pad_q    <= PAD_IDX_W'(IO_PADS - 1);   // Highest pad goes first
                    bit_q    <= '0;
                    if (xfer_start_i) begin
                        state_q <= LD_START;
                    end
                end

                LD_START: begin
                    clock_q <= 1'b0;
                    bit_q   <= '0;
                    state_q <= LD_SHIFT;
                end

                // Two cycles per bit, low then high
                LD_SHIFT: begin
                    if (!clock_q) begin
                        clock_q <= 1'b1;
                    end else if (last_bit) begin
                        bit_q <= '0;
                        if (last_pad) begin
                            state_q <= LD_LATCH;   // Clock stays high into the latch
                        end else begin
                            clock_q <= 1'b0;
                            pad_q   <= pad_q - 1'b1;
                            state_q <= LD_START;
                        end
                    end else begin
                        clock_q <= 1'b0;
                        bit_q   <= bit_q + 1'b1;
                    end
                end

                // Pulse chain reset low while clock is high, then drop clock
                LD_LATCH: begin
                    bit_q <= bit_q + 1'b1;
                    case (bit_q)
                        BIT_IDX_W'(0): resetn_q <= 1'b0;
                        BIT_IDX_W'(1): resetn_q <= 1'b1;
                        BIT_IDX_W'(2): clock_q  <= 1'b0;
                        default:       state_q  <= LD_IDLE;
                    endcase
                end

                default: state_q <= LD_IDLE;
            endcase
        end
    end

    // Word capture and MSB first shift, data moves on the falling clock edge
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            staging_q <= '0;
        end else if (state_q == LD_START) begin
            staging_q <= pad_ctrl_i[pad_q];
        end else if ((state_q == LD_SHIFT) && clock_q) begin
            staging_q <= {staging_q[IO_CTRL_BITS-2:0], 1'b0};
        end
    end

    assign busy_o = (state_q != LD_IDLE);

    always_comb begin
        serial_o.clock  = clock_q;
        serial_o.resetn = resetn_q;
        serial_o.data   = staging_q[IO_CTRL_BITS-1];
    end

endmodule

`default_nettype wire

//--- gpio_ctrl_top.sv
`default_nettype none

module gpio_ctrl_top (
    input  wire                                clk,
    input  wire                                resetn,
    input  gpio_ctrl_pkg::wb_req_t             wb_req_i,
    input  wire [gpio_ctrl_pkg::IO_PADS-1:0]   mgmt_gpio_in_i,
    output logic [31:0]                        wb_dat_o,
    output logic                               wb_ack_o,
    output gpio_ctrl_pkg::serial_out_t         serial_o,
    output logic [gpio_ctrl_pkg::IO_PADS-1:0]  mgmt_gpio_out_o,
    output logic [gpio_ctrl_pkg::IO_PADS-1:0]  mgmt_gpio_oe_o
);
    import gpio_ctrl_pkg::*;

    reg_access_t access;      // Decode to register stage
    pad_ctrl_t   pad_ctrl;    // Register stage to loader
    logic        xfer_start;
    logic        busy;

    wb_bus_decode u_decode (
        .req_i    (wb_req_i),
        .access_o (access)
    );

    gpio_ctrl_regs u_regs (
        .clk             (clk),
        .resetn          (resetn),
        .access_i        (access),
        .mgmt_gpio_in_i  (mgmt_gpio_in_i),
        .busy_i          (busy),
        .rdata_o         (wb_dat_o),
        .ack_o           (wb_ack_o),
        .xfer_start_o    (xfer_start),
        .pad_ctrl_o      (pad_ctrl),
        .mgmt_gpio_out_o (mgmt_gpio_out_o),
        .mgmt_gpio_oe_o  (mgmt_gpio_oe_o)
    );

    pad_serial_loader u_loader (
        .clk          (clk),
        .resetn       (resetn),
        .xfer_start_i (xfer_start),
        .pad_ctrl_i   (pad_ctrl),
        .busy_o       (busy),
        .serial_o     (serial_o)
    );

endmodule

`default_nettype wire

//--- tb_gpio_ctrl.sv
`default_nettype none

module tb_gpio_ctrl;
    import gpio_ctrl_pkg::*;

    logic               clk;
    logic               resetn;
    wb_req_t            wb_req;
    logic [IO_PADS-1:0] gpio_in;
    logic [31:0]        wb_dat;
    logic               wb_ack;
    serial_out_t        serial;
    logic [IO_PADS-1:0] gpio_out;
    logic [IO_PADS-1:0] gpio_oe;

    // Register model
    logic [IO_PADS-1:0] model_data;
    pad_ctrl_t          model_ctrl;
    logic               model_busy;

    // Serial chain model, first bit shifted in ends up at the top
    logic [IO_PADS*IO_CTRL_BITS-1:0] chain = '0;
    pad_ctrl_t          latched = '0;
    int                 rise_count = 0;
    int                 latch_count = 0;
    logic               ser_clock;
    logic               ser_resetn;

    integer             seed = 32'hb1e3b214;

    gpio_ctrl_top DUT (
        .clk             (clk),
        .resetn          (resetn),
        .wb_req_i        (wb_req),
        .mgmt_gpio_in_i  (gpio_in),
        .wb_dat_o        (wb_dat),
        .wb_ack_o        (wb_ack),
        .serial_o        (serial),
        .mgmt_gpio_out_o (gpio_out),
        .mgmt_gpio_oe_o  (gpio_oe)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign ser_clock  = serial.clock;
    assign ser_resetn = serial.resetn;

    always @(posedge ser_clock) begin
        if (resetn) begin
            chain      <= {chain[IO_PADS*IO_CTRL_BITS-2:0], serial.data};
            rise_count <= rise_count + 1;
        end
    end

    // Chain contents are latched when its reset drops with the clock high
    always @(negedge ser_resetn) begin
        if (resetn && ser_clock === 1'b1) begin
            latched     = chain;
            latch_count = latch_count + 1;
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("mismatch at %0t: %s expected %h, got %h",
                                      $time, name, exp, act));
        end
    endtask

    task automatic check_region_mask(input string name, input logic [IO_PADS-1:0] exp,
                                     input logic [IO_PADS-1:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("mismatch at %0t: %s expected %h, got %h",
                                      $time, name, exp, act));
        end
    endtask

    task automatic check_pad_ctrl(input int pad, input pad_ctrl_t exp, input pad_ctrl_t act);
        if (act[pad] !== exp[pad]) begin
            stop_with_error($sformatf("mismatch at %0t: serial chain pad %0d expected %h, got %h",
                                      $time, pad, exp[pad], act[pad]));
        end
    endtask

    task automatic check_line(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_error($sformatf("mismatch at %0t: %s expected %b, got %b",
                                      $time, name, exp, act));
        end
    endtask

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic logic [7:0] pad_ofs(input logic [PAD_IDX_W-1:0] pad);
        return IO_CTRL_OFS + {2'b00, pad, 2'b00};
    endfunction

    // Pad number of a configuration offset, -1 when not a pad register
    function automatic int pad_slot(input logic [7:0] ofs);
        if (ofs < IO_CTRL_OFS || ofs[1:0] != 2'b00) return -1;
        if (int'(ofs) >= int'(IO_CTRL_OFS) + 4 * IO_PADS) return -1;
        return (int'(ofs) - int'(IO_CTRL_OFS)) / 4;
    endfunction

    function automatic logic [IO_PADS-1:0] expected_oe();
        logic [IO_PADS-1:0] oe;
        for (int i = 0; i < IO_PADS; i++) begin
            oe[i] = model_ctrl[i][INP_DIS_BIT];
        end
        return oe;
    endfunction

    // One Wishbone access, returns when ack is seen
    task automatic bus_cycle(input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, input logic we,
                             output logic [31:0] rdata);
        int waited;
        waited = 0;
        wb_req = '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 20) stop_with_error($sformatf("no acknowledge for address %h", adr));
        end while (!wb_ack);
        rdata  = wb_dat;
        wb_req = '0;
    endtask

    task automatic write_reg(input logic [7:0] ofs, input logic [31:0] dat,
                             input logic [3:0] sel);
        logic [31:0] unused;
        int          slot;
        slot = pad_slot(ofs);
        bus_cycle(BASE_ADR | {24'd0, ofs}, dat, sel, 1'b1, unused);
        if (sel[0]) begin  // Upper lanes alone leave state untouched
            if (ofs == DATA_OFS) model_data = dat[IO_PADS-1:0];
            else if (ofs == XFER_OFS && dat[0]) model_busy = 1'b1;
            else if (slot >= 0) model_ctrl[slot] = dat[IO_CTRL_BITS-1:0];
        end
        check_region_mask("mgmt_gpio_out_o", model_data, gpio_out);
        check_region_mask("mgmt_gpio_oe_o", expected_oe(), gpio_oe);
    endtask

    task automatic read_check(input logic [7:0] ofs, input logic [3:0] sel);
        logic [31:0] rd;
        logic [31:0] exp;
        int          slot;
        slot = pad_slot(ofs);
        exp  = 32'd0;  // Unmapped offsets
        if (ofs == DATA_OFS) exp = {{(32-IO_PADS){1'b0}}, gpio_in};
        else if (ofs == XFER_OFS) exp = {31'd0, model_busy};
        else if (slot >= 0) exp = {{(32-IO_CTRL_BITS){1'b0}}, model_ctrl[slot]};
        bus_cycle(BASE_ADR | {24'd0, ofs}, next_rand(), sel, 1'b0, rd);
        check_word($sformatf("wb_dat_o offset %h", ofs), exp, rd);
    endtask

    task automatic expect_no_ack(input logic [31:0] adr);
        wb_req = '{adr: adr, dat: next_rand(), sel: 4'hf, we: 1'b1, cyc: 1'b1, stb: 1'b1};
        repeat (8) begin
            @(posedge clk);
            #1;
            check_line($sformatf("wb_ack_o for address %h", adr), 1'b0, wb_ack);
        end
        wb_req = '0;
    endtask

    task automatic wait_serial_edges(input int count);
        int cycles;
        cycles = 0;
        while (rise_count < count) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 1000) stop_with_error("serial clock stopped during the transfer");
        end
    endtask

    // Poll busy until the loader is idle, then check the latched chain
    task automatic finish_transfer(input int rise0, input int latch0);
        logic [31:0] rd;
        int          polls;
        polls = 0;
        read_check(XFER_OFS, 4'hf);
        do begin
            bus_cycle(BASE_ADR | {24'd0, XFER_OFS}, 32'd0, 4'hf, 1'b0, rd);
            polls++;
            if (polls > 300) stop_with_error("transfer register stayed busy too long");
        end while (rd[0]);
        model_busy = 1'b0;
        check_word("wb_dat_o transfer idle", 32'd0, rd);
        repeat (3) read_check(XFER_OFS, 4'hf);  // Busy must not come back
        if (latch_count - latch0 != 1)
            stop_with_error($sformatf("expected one latch pulse, saw %0d", latch_count - latch0));
        if (rise_count - rise0 != IO_PADS * IO_CTRL_BITS)
            stop_with_error($sformatf("wrong serial clock count %0d", rise_count - rise0));
        for (int i = 0; i < IO_PADS; i++) check_pad_ctrl(i, model_ctrl, latched);
    endtask

    initial begin
        logic [31:0] rnd;
        logic [7:0]  unmapped [8];
        int          rise0;
        int          latch0;
        int          cycles;
        wb_req     = '0;
        gpio_in    = '0;
        resetn     = 1'b0;
        model_data = '0;
        model_busy = 1'b0;
        for (int i = 0; i < IO_PADS; i++) begin
            model_ctrl[i] = (i < 2) ? 13'h1801 : 13'h0403;
        end
        repeat (16) @(posedge clk);
        #1;
        check_line("wb_ack_o", 1'b0, wb_ack);
        check_line("serial_o.clock", 1'b0, serial.clock);
        check_line("serial_o.resetn", 1'b0, serial.resetn);
        resetn = 1'b1;

        cycles = 0;
        while (serial.resetn !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 10) stop_with_error("serial reset never released after reset");
        end

        // Reset values
        for (int i = 0; i < IO_PADS; i++) read_check(pad_ofs(i[PAD_IDX_W-1:0]), 4'hf);
        check_region_mask("mgmt_gpio_oe_o", expected_oe(), gpio_oe);
        check_region_mask("mgmt_gpio_out_o", model_data, gpio_out);
        read_check(XFER_OFS, 4'hf);

        // Random register traffic
        for (int n = 0; n < 300; n++) begin
            rnd     = next_rand();
            gpio_in = next_rand();
            case (rnd[9:8])
                2'd0:    write_reg(DATA_OFS, next_rand(), rnd[3:0]);
                2'd1:    write_reg(pad_ofs(rnd[7:4]), next_rand(), rnd[3:0]);
                2'd2:    read_check(DATA_OFS, rnd[3:0]);
                default: read_check(pad_ofs(rnd[7:4]), rnd[3:0]);
            endcase
        end

        // Unmapped offsets, writes are dropped and reads give zero
        unmapped = '{8'h08, 8'h0c, 8'h10, 8'h1c, 8'h22, 8'h60, 8'h80, 8'hfc};
        for (int k = 0; k < 8; k++) begin
            write_reg(unmapped[k], next_rand(), 4'hf);
            read_check(unmapped[k], 4'hf);
        end
        expect_no_ack(32'h2400_0020);
        expect_no_ack(32'h2300_0100);
        expect_no_ack(32'h0000_0004);
        for (int i = 0; i < IO_PADS; i++) read_check(pad_ofs(i[PAD_IDX_W-1:0]), 4'hf);
        check_region_mask("mgmt_gpio_out_o", model_data, gpio_out);
        read_check(XFER_OFS, 4'hf);

        // Serial load of random configurations
        for (int i = 0; i < IO_PADS; i++) write_reg(pad_ofs(i[PAD_IDX_W-1:0]), next_rand(), 4'h1);
        rise0  = rise_count;
        latch0 = latch_count;
        write_reg(XFER_OFS, 32'h1, 4'hf);
        finish_transfer(rise0, latch0);

        // Second start and late pad writes while the chain is shifting
        for (int i = 0; i < IO_PADS; i++) write_reg(pad_ofs(i[PAD_IDX_W-1:0]), next_rand(), 4'h1);
        rise0  = rise_count;
        latch0 = latch_count;
        write_reg(XFER_OFS, 32'h1, 4'hf);
        write_reg(XFER_OFS, 32'h1, 4'hf);   // Ignored by the busy loader
        wait_serial_edges(rise0 + 2 * IO_CTRL_BITS);
        for (int n = 0; n < 8; n++) begin
            rnd = next_rand();
            write_reg(pad_ofs({1'b0, rnd[2:0]}), next_rand(), rnd[7:4]);
        end
        finish_transfer(rise0, latch0);

        $display("Finished with no errors");
        $finish;
    end

    initial begin
        repeat (20000) @(posedge clk);
        stop_with_error("simulation watchdog expired");
    end

endmodule

`default_nettype wire

//--- sources.f
gpio_ctrl_pkg.sv
wb_bus_decode.sv
gpio_ctrl_regs.sv
pad_serial_loader.sv
gpio_ctrl_top.sv
tb_gpio_ctrl.sv

//--- Makefile
SIM      = verilator
TOP      = tb_gpio_ctrl
FILELIST = sources.f
FLAGS    = --binary --timing -Wno-fatal
OBJ_DIR  = obj_dir

SOURCES  = $(shell cat $(FILELIST))
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
